//--- common/exu_pkg.sv
package exu_pkg;

  localparam int xlen = 64;

  // instruction class, set by decode
  typedef enum logic [3:0] {
    op_alu,
    op_load,
    op_store,
    op_jal,
    op_jalr,
    op_branch,
    op_csr,
    op_ecall,
    op_ebreak,
    op_mret
  } op_class_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // same codes as funct3
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } br_func_e;

  // immediate forms arrive with zimm already in src1
  typedef enum logic [1:0] {
    csr_rw = 2'b01,
    csr_rs = 2'b10,
    csr_rc = 2'b11
  } csr_func_e;

  localparam logic [11:0] csr_mstatus  = 12'h300;
  localparam logic [11:0] csr_mtvec    = 12'h305;
  localparam logic [11:0] csr_mscratch = 12'h340;
  localparam logic [11:0] csr_mepc     = 12'h341;
  localparam logic [11:0] csr_mcause   = 12'h342;

  localparam logic [xlen-1:0] cause_ecall_m = 64'd11;

  // uxl/sxl field set, everything else clear
  localparam logic [xlen-1:0] mstatus_rst = 64'h0000_000a_0000_0000;
  localparam int mstatus_mie  = 3;
  localparam int mstatus_mpie = 7;

  typedef struct packed {
    op_class_e       op_class;
    alu_op_e         alu_op;
    br_func_e        br_func;
    csr_func_e       csr_func;
    logic [11:0]     csr_addr;
    logic [4:0]      rd;
    logic            rwen;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] pc;
    // jalr and address base register
    logic [xlen-1:0] base;
  } issue_t;

  typedef struct packed {
    logic            write;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic            rwen;
    logic [xlen-1:0] wdata;
    logic            redirect;
    logic [xlen-1:0] npc;
    logic            ebreak;
  } wb_t;

endpackage

//--- exu/exu_alu.sv
module exu_alu import exu_pkg::*; (
  input  alu_op_e         op_i,
  input  logic [xlen-1:0] a_i,
  input  logic [xlen-1:0] b_i,
  output logic [xlen-1:0] res_o
);

  logic [5:0] shamt;
  logic       lt_s;
  logic       lt_u;

  // rv64 shifts take six bits
  assign shamt = b_i[5:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (op_i)
      alu_add:  res_o = a_i + b_i;
      alu_sub:  res_o = a_i - b_i;
      alu_sll:  res_o = a_i << shamt;
      alu_slt:  res_o = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: res_o = {{(xlen-1){1'b0}}, lt_u};
      alu_xor:  res_o = a_i ^ b_i;
      alu_srl:  res_o = a_i >> shamt;
      alu_sra:  res_o = $unsigned($signed(a_i) >>> shamt);
      alu_or:   res_o = a_i | b_i;
      alu_and:  res_o = a_i & b_i;
      default:  res_o = '0;
    endcase
  end

endmodule

//--- exu/exu_branch.sv
module exu_branch import exu_pkg::*; (
  input  issue_t          issue_i,
  input  logic [xlen-1:0] mtvec_i,
  input  logic [xlen-1:0] mepc_i,
  output logic            redirect_o,
  output logic [xlen-1:0] npc_o,
  output logic [xlen-1:0] link_o
);

  logic [xlen-1:0] seq_pc;
  logic [xlen-1:0] pc_target;
  logic [xlen-1:0] jalr_target;
  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic            taken;

  assign seq_pc      = issue_i.pc + xlen'(4);
  assign pc_target   = issue_i.pc + issue_i.imm;
  assign jalr_target = (issue_i.base + issue_i.imm) & ~xlen'(1);

  assign eq   = issue_i.src1 == issue_i.src2;
  assign lt_s = $signed(issue_i.src1) < $signed(issue_i.src2);
  assign lt_u = issue_i.src1 < issue_i.src2;

  always_comb begin
    case (issue_i.br_func)
      br_beq:  taken = eq;
      br_bne:  taken = !eq;
      br_blt:  taken = lt_s;
      br_bge:  taken = !lt_s;
      br_bltu: taken = lt_u;
      br_bgeu: taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    redirect_o = 1'b0;
    npc_o      = seq_pc;
    case (issue_i.op_class)
      op_branch: begin
        redirect_o = taken;
        if (taken) npc_o = pc_target;
      end
      op_jal: begin
        redirect_o = 1'b1;
        npc_o      = pc_target;
      end
      op_jalr: begin
        redirect_o = 1'b1;
        npc_o      = jalr_target;
      end
      op_ecall: begin
        redirect_o = 1'b1;
        npc_o      = mtvec_i;
      end
      // ebreak stops at itself
      op_ebreak: begin
        redirect_o = 1'b1;
        npc_o      = issue_i.pc;
      end
      op_mret: begin
        redirect_o = 1'b1;
        npc_o      = mepc_i;
      end
      default: ;
    endcase
  end

  assign link_o = seq_pc;

endmodule

//--- exu/exu_csr_file.sv
module exu_csr_file import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  issue_t          issue_i,
  input  logic            commit_i,
  output logic [xlen-1:0] rdata_o,
  output logic [xlen-1:0] mtvec_o,
  output logic [xlen-1:0] mepc_o
);

  logic [xlen-1:0] mstatus_q;
  logic [xlen-1:0] mtvec_q;
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] mcause_q;
  logic [xlen-1:0] mscratch_q;
  logic [xlen-1:0] wdata;
  logic            csr_wr;
  logic            ecall_wr;
  logic            mret_wr;

  // unknown addresses read zero
  always_comb begin
    case (issue_i.csr_addr)
      csr_mstatus:  rdata_o = mstatus_q;
      csr_mtvec:    rdata_o = mtvec_q;
      csr_mepc:     rdata_o = mepc_q;
      csr_mcause:   rdata_o = mcause_q;
      csr_mscratch: rdata_o = mscratch_q;
      default:      rdata_o = '0;
    endcase
  end

  always_comb begin
    case (issue_i.csr_func)
      csr_rw:  wdata = issue_i.src1;
      csr_rs:  wdata = rdata_o | issue_i.src1;
      csr_rc:  wdata = rdata_o & ~issue_i.src1;
      default: wdata = rdata_o;
    endcase
  end

  assign csr_wr   = commit_i && (issue_i.op_class == op_csr);
  assign ecall_wr = commit_i && (issue_i.op_class == op_ecall);
  assign mret_wr  = commit_i && (issue_i.op_class == op_mret);

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q  <= mstatus_rst;
      mtvec_q    <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mscratch_q <= '0;
    end else begin
      if (csr_wr) begin
        case (issue_i.csr_addr)
          csr_mstatus:  mstatus_q  <= wdata;
          csr_mtvec:    mtvec_q    <= wdata;
          csr_mepc:     mepc_q     <= wdata;
          csr_mcause:   mcause_q   <= wdata;
          csr_mscratch: mscratch_q <= wdata;
          default: ;
        endcase
      end
      if (ecall_wr) begin
        mepc_q   <= issue_i.pc;
        mcause_q <= cause_ecall_m;
      end
      // trap return: mie from mpie, mpie set
      if (mret_wr) begin
        mstatus_q[mstatus_mie]  <= mstatus_q[mstatus_mpie];
        mstatus_q[mstatus_mpie] <= 1'b1;
      end
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

endmodule

//--- exu/exu_ctrl.sv
module exu_ctrl import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,

  input  logic            issue_valid_i,
  output logic            issue_ready_o,
  input  issue_t          issue_i,

  output logic            mem_req_valid_o,
  output mem_req_t        mem_req_o,
  input  logic            mem_resp_valid_i,
  input  logic [xlen-1:0] mem_rdata_i,

  output logic            wb_valid_o,
  input  logic            wb_ready_i,
  output wb_t             wb_o,

  output issue_t          issue_q_o,
  input  logic [xlen-1:0] alu_res_i,
  input  logic [xlen-1:0] csr_rdata_i,
  input  logic            redirect_i,
  input  logic [xlen-1:0] npc_i,
  input  logic [xlen-1:0] link_i,
  output logic            csr_commit_o
);

  typedef enum logic [1:0] {st_idle, st_mem_wait, st_done} state_e;

  state_e          state_q, state_d;
  issue_t          issue_q;
  logic [xlen-1:0] load_q;
  logic            issue_fire;
  logic            issue_is_mem;

  assign issue_ready_o = (state_q == st_idle) || (state_q == st_done && wb_ready_i);
  assign issue_fire    = issue_valid_i && issue_ready_o;
  assign issue_is_mem  = issue_i.op_class inside {op_load, op_store};

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: if (issue_fire) state_d = issue_is_mem ? st_mem_wait : st_done;
      st_mem_wait: if (mem_resp_valid_i) state_d = st_done;
      st_done: begin
        // handoff and new capture can share an edge
        if (wb_ready_i) begin
          if (issue_fire) state_d = issue_is_mem ? st_mem_wait : st_done;
          else state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_fire) issue_q <= issue_i;
    if (state_q == st_mem_wait && mem_resp_valid_i) load_q <= mem_rdata_i;
  end

  assign issue_q_o       = issue_q;
  assign mem_req_valid_o = (state_q == st_mem_wait);
  assign wb_valid_o      = (state_q == st_done);
  assign csr_commit_o    = wb_valid_o && wb_ready_i;

  always_comb begin
    mem_req_o.write = (issue_q.op_class == op_store);
    mem_req_o.addr  = issue_q.base + issue_q.imm;
    mem_req_o.wdata = issue_q.src2;
  end

  always_comb begin
    wb_o.rd   = issue_q.rd;
    // no register write for stores and branches
    wb_o.rwen = issue_q.rwen && !(issue_q.op_class inside {op_store, op_branch});
    case (issue_q.op_class)
      op_load:         wb_o.wdata = load_q;
      op_csr:          wb_o.wdata = csr_rdata_i;
      op_jal, op_jalr: wb_o.wdata = link_i;
      default:         wb_o.wdata = alu_res_i;
    endcase
    wb_o.redirect = redirect_i;
    wb_o.npc      = npc_i;
    wb_o.ebreak   = (issue_q.op_class == op_ebreak);
  end

  mem_req_hold_a: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid_o && !mem_resp_valid_i |=> mem_req_valid_o && $stable(mem_req_o));

  // covers csr read data as well, so no csr update may slip in during a stall
  wb_hold_a: assert property (@(posedge clk) disable iff (rst)
    wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_o));

endmodule

//--- exu/exu_top.sv
module exu_top import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,

  input  logic            issue_valid_i,
  output logic            issue_ready_o,
  input  issue_t          issue_i,

  output logic            mem_req_valid_o,
  output mem_req_t        mem_req_o,
  input  logic            mem_resp_valid_i,
  input  logic [xlen-1:0] mem_rdata_i,

  output logic            wb_valid_o,
  input  logic            wb_ready_i,
  output wb_t             wb_o
);

  issue_t          issue_q;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] csr_rdata;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic            redirect;
  logic [xlen-1:0] npc;
  logic [xlen-1:0] link;
  logic            csr_commit;

  exu_ctrl exu_ctrl_inst (
    .clk              (clk),
    .rst              (rst),
    .issue_valid_i    (issue_valid_i),
    .issue_ready_o    (issue_ready_o),
    .issue_i          (issue_i),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_o        (mem_req_o),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_rdata_i      (mem_rdata_i),
    .wb_valid_o       (wb_valid_o),
    .wb_ready_i       (wb_ready_i),
    .wb_o             (wb_o),
    .issue_q_o        (issue_q),
    .alu_res_i        (alu_res),
    .csr_rdata_i      (csr_rdata),
    .redirect_i       (redirect),
    .npc_i            (npc),
    .link_i           (link),
    .csr_commit_o     (csr_commit)
  );

  exu_alu exu_alu_inst (
    .op_i  (issue_q.alu_op),
    .a_i   (issue_q.src1),
    .b_i   (issue_q.src2),
    .res_o (alu_res)
  );

  exu_branch exu_branch_inst (
    .issue_i    (issue_q),
    .mtvec_i    (mtvec),
    .mepc_i     (mepc),
    .redirect_o (redirect),
    .npc_o      (npc),
    .link_o     (link)
  );

  exu_csr_file exu_csr_file_inst (
    .clk      (clk),
    .rst      (rst),
    .issue_i  (issue_q),
    .commit_i (csr_commit),
    .rdata_o  (csr_rdata),
    .mtvec_o  (mtvec),
    .mepc_o   (mepc)
  );

endmodule

//--- tests/exu_tb.sv
module exu_tb import exu_pkg::*; ();

  localparam int n_random  = 320;
  localparam int n_instr   = 400;
  // 12 cycles per instruction, plus reset
  localparam int timeout_t = (n_instr * 12 + 10) * 10;
  localparam int mie_bit   = 3;
  localparam int mpie_bit  = 7;

  logic            clk;
  logic            rst;
  logic            issue_valid_i;
  logic            issue_ready_o;
  issue_t          issue_i;
  logic            mem_req_valid_o;
  mem_req_t        mem_req_o;
  logic            mem_resp_valid_i;
  logic [xlen-1:0] mem_rdata_i;
  logic            wb_valid_o;
  logic            wb_ready_i;
  wb_t             wb_o;

  logic [15:0]     lfsr_q;
  logic [xlen-1:0] mem_model [16];
  logic [xlen-1:0] ref_mem [16];
  logic [xlen-1:0] m_mstatus;
  logic [xlen-1:0] m_mtvec;
  logic [xlen-1:0] m_mepc;
  logic [xlen-1:0] m_mcause;
  logic [xlen-1:0] m_mscratch;
  wb_t             expect_q [$];

  br_func_e    br_list [6]  = '{br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};
  // last entry is not a implemented csr
  logic [11:0] csr_list [6] = '{csr_mstatus, csr_mtvec, csr_mepc, csr_mcause, csr_mscratch,
                                12'h7c0};

  exu_top exu_top_inst (
    .clk              (clk),
    .rst              (rst),
    .issue_valid_i    (issue_valid_i),
    .issue_ready_o    (issue_ready_o),
    .issue_i          (issue_i),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_o        (mem_req_o),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_rdata_i      (mem_rdata_i),
    .wb_valid_o       (wb_valid_o),
    .wb_ready_i       (wb_ready_i),
    .wb_o             (wb_o)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%0t: %s", $time, why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [159:0] got,
                           input logic [159:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %0h expected %0h", $time, name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[62:0], fb};
    end
    return r;
  endfunction

  function automatic logic [xlen-1:0] alu_ref(input alu_op_e op, input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b);
    logic [xlen-1:0] r;
    case (op)
      alu_add:  r = a + b;
      alu_sub:  r = a - b;
      alu_sll:  r = a << b[5:0];
      alu_slt:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      alu_sltu: r = (a < b) ? 64'd1 : 64'd0;
      alu_xor:  r = a ^ b;
      alu_srl:  r = a >> b[5:0];
      alu_sra:  r = $unsigned($signed(a) >>> b[5:0]);
      alu_or:   r = a | b;
      default:  r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic br_taken(input br_func_e f, input logic [xlen-1:0] a,
                                    input logic [xlen-1:0] b);
    logic t;
    case (f)
      br_beq:  t = (a == b);
      br_bne:  t = (a != b);
      br_blt:  t = ($signed(a) < $signed(b));
      br_bge:  t = ($signed(a) >= $signed(b));
      br_bltu: t = (a < b);
      default: t = (a >= b);
    endcase
    return t;
  endfunction

  function automatic logic [xlen-1:0] csr_read(input logic [11:0] addr);
    case (addr)
      csr_mstatus:  return m_mstatus;
      csr_mtvec:    return m_mtvec;
      csr_mepc:     return m_mepc;
      csr_mcause:   return m_mcause;
      csr_mscratch: return m_mscratch;
      default:      return '0;
    endcase
  endfunction

  // expected writeback, also advances the model csr and memory state
  function automatic wb_t ref_wb(input issue_t it);
    wb_t             w;
    logic [xlen-1:0] old;
    logic [xlen-1:0] nxt;
    logic [xlen-1:0] addr;
    old        = csr_read(it.csr_addr);
    addr       = it.base + it.imm;
    w.rd       = it.rd;
    w.rwen     = it.rwen && !(it.op_class inside {op_store, op_branch});
    w.wdata    = alu_ref(it.alu_op, it.src1, it.src2);
    w.redirect = 1'b0;
    w.npc      = it.pc + 64'd4;
    w.ebreak   = 1'b0;
    case (it.op_class)
      op_load:  w.wdata = ref_mem[addr[6:3]];
      op_store: ref_mem[addr[6:3]] = it.src2;
      op_jal, op_jalr: begin
        w.wdata    = it.pc + 64'd4;
        w.redirect = 1'b1;
        w.npc      = (it.op_class == op_jal) ? it.pc + it.imm : addr & ~64'd1;
      end
      op_branch: begin
        w.redirect = br_taken(it.br_func, it.src1, it.src2);
        if (w.redirect) w.npc = it.pc + it.imm;
      end
      op_csr: begin
        w.wdata = old;
        case (it.csr_func)
          csr_rw:  nxt = it.src1;
          csr_rs:  nxt = old | it.src1;
          default: nxt = old & ~it.src1;
        endcase
        case (it.csr_addr)
          csr_mstatus:  m_mstatus  = nxt;
          csr_mtvec:    m_mtvec    = nxt;
          csr_mepc:     m_mepc     = nxt;
          csr_mcause:   m_mcause   = nxt;
          csr_mscratch: m_mscratch = nxt;
          default: ;
        endcase
      end
      op_ecall: begin
        w.redirect = 1'b1;
        w.npc      = m_mtvec;
        m_mepc     = it.pc;
        m_mcause   = 64'd11;
      end
      op_ebreak: begin
        w.redirect = 1'b1;
        w.npc      = it.pc;
        w.ebreak   = 1'b1;
      end
      op_mret: begin
        w.redirect          = 1'b1;
        w.npc               = m_mepc;
        m_mstatus[mie_bit]  = m_mstatus[mpie_bit];
        m_mstatus[mpie_bit] = 1'b1;
      end
      default: ;
    endcase
    return w;
  endfunction

  function automatic issue_t blank_issue(input op_class_e cls, input logic [xlen-1:0] pc);
    issue_t it;
    it          = '0;
    it.op_class = cls;
    it.alu_op   = alu_add;
    it.br_func  = br_beq;
    it.csr_func = csr_rs;
    it.rd       = 5'd1;
    it.rwen     = 1'b1;
    it.pc       = pc;
    return it;
  endfunction

  function automatic issue_t rand_issue();
    issue_t          it;
    logic [3:0]      idx;
    logic [xlen-1:0] off;
    it          = blank_issue(op_class_e'(4'(rand_bits(4) % 64'd10)), rand_bits(62) << 2);
    it.alu_op   = alu_op_e'(4'(rand_bits(4) % 64'd10));
    it.br_func  = br_list[int'(rand_bits(3) % 64'd6)];
    it.csr_func = csr_func_e'(2'(rand_bits(2) % 64'd3 + 64'd1));
    it.csr_addr = csr_list[int'(rand_bits(3) % 64'd6)];
    it.rd       = 5'(rand_bits(5));
    it.rwen     = 1'(rand_bits(1));
    it.src1     = rand_bits(64);
    it.src2     = (rand_bits(2) == 64'd0) ? it.src1 : rand_bits(64);
    it.imm      = 64'($signed(12'(rand_bits(12))));
    it.base     = rand_bits(64);
    // keep memory addresses inside the 16-word model
    if (it.op_class inside {op_load, op_store}) begin
      idx     = 4'(rand_bits(4));
      off     = rand_bits(5) << 3;
      it.imm  = off;
      it.base = {57'd0, idx, 3'd0} - off;
    end
    return it;
  endfunction

  // the model runs at acceptance, so expected records follow issue order
  task automatic send_issue(input issue_t it);
    issue_valid_i = 1'b1;
    issue_i       = it;
    @(negedge clk);
    while (!issue_ready_o) @(negedge clk);
    expect_q.push_back(ref_wb(it));
    @(posedge clk);
    #1;
    issue_valid_i = 1'b0;
  endtask

  task automatic send_csr(input csr_func_e f, input logic [11:0] addr,
                          input logic [xlen-1:0] val);
    issue_t it;
    it          = blank_issue(op_csr, 64'h1000);
    it.csr_func = f;
    it.csr_addr = addr;
    it.src1     = val;
    send_issue(it);
  endtask

  initial begin
    issue_t it;
    clk              = 1'b0;
    rst              = 1'b1;
    issue_valid_i    = 1'b0;
    issue_i          = '0;
    mem_resp_valid_i = 1'b0;
    mem_rdata_i      = '0;
    wb_ready_i       = 1'b0;
    lfsr_q           = 16'd52;
    m_mstatus        = 64'h0000_000a_0000_0000;
    m_mtvec          = '0;
    m_mepc           = '0;
    m_mcause         = '0;
    m_mscratch       = '0;
    for (int i = 0; i < 16; i++) begin
      mem_model[i] = {4{16'(i) ^ 16'h5a3c}};
      ref_mem[i]   = mem_model[i];
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    check_val("issue_ready_o", 160'(issue_ready_o), 160'(1'b1));
    check_val("wb_valid_o", 160'(wb_valid_o), 160'(1'b0));
    check_val("mem_req_valid_o", 160'(mem_req_valid_o), 160'(1'b0));

    send_csr(csr_rw, csr_mtvec, 64'h8000_0400);
    send_csr(csr_rw, csr_mscratch, 64'hdead_beef_0123_4567);
    send_csr(csr_rs, csr_mscratch, 64'h0000_0000_0000_00f0);
    send_csr(csr_rc, csr_mscratch, 64'h0f00_0000_0000_0007);
    send_csr(csr_rs, csr_mscratch, 64'd0);
    send_csr(csr_rw, 12'h7c0, 64'hffff);
    send_issue(blank_issue(op_ecall, 64'h2000));
    send_csr(csr_rs, csr_mepc, 64'd0);
    send_csr(csr_rs, csr_mcause, 64'd0);
    send_issue(blank_issue(op_mret, 64'h8000_0400));
    send_csr(csr_rs, csr_mstatus, 64'd0);
    send_issue(blank_issue(op_ebreak, 64'h2100));
    it     = blank_issue(op_jal, 64'h3000);
    it.imm = 64'h40;
    send_issue(it);
    it      = blank_issue(op_jalr, 64'h3004);
    it.base = 64'h5001;
    it.imm  = 64'h10;
    send_issue(it);

    for (int i = 0; i < n_random; i++) begin
      send_issue(rand_issue());
      if (rand_bits(2) == 64'd0) begin
        @(posedge clk);
        #1;
      end
    end

    // a few idle cycles so a stray extra result is still caught
    while (expect_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    $display("Testbench passed");
    $finish;
  end

  // result compare and hold check under back-pressure
  initial begin
    wb_t  held;
    logic stalled;
    stalled = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (stalled) begin
          check_val("wb_valid_o", 160'(wb_valid_o), 160'(1'b1));
          check_val("wb_o", 160'(wb_o), 160'(held));
        end
        stalled = wb_valid_o && !wb_ready_i;
        held    = wb_o;
        if (wb_valid_o && wb_ready_i) begin
          if (expect_q.size() == 0) begin
            abort_run("result handed off with no instruction outstanding");
          end else begin
            check_val("wb_o", 160'(wb_o), 160'(expect_q.pop_front()));
          end
        end
      end
    end
  end

  // memory responder with 0 to 7 cycles of latency
  initial begin
    logic [2:0] lat;
    forever begin
      @(posedge clk);
      #1;
      if (!rst && mem_req_valid_o) begin
        if (mem_req_o.addr > 64'd120 || mem_req_o.addr[2:0] != 3'd0) begin
          abort_run("memory request address outside the memory model");
        end else begin
          lat = 3'(rand_bits(3));
          repeat (lat) begin
            @(posedge clk);
            #1;
          end
          mem_resp_valid_i = 1'b1;
          mem_rdata_i      = mem_model[mem_req_o.addr[6:3]];
          if (mem_req_o.write) mem_model[mem_req_o.addr[6:3]] = mem_req_o.wdata;
          @(posedge clk);
          #1;
          mem_resp_valid_i = 1'b0;
        end
      end
    end
  end

  initial begin
    @(negedge rst);
    forever begin
      @(posedge clk);
      #1;
      wb_ready_i = (rand_bits(2) != 64'd0);
    end
  end

  initial begin
    #(timeout_t);
    abort_run("watchdog timeout, the instruction stream did not finish in time");
  end

endmodule

//--- exu.f
common/exu_pkg.sv
exu/exu_alu.sv
exu/exu_branch.sv
exu/exu_csr_file.sv
exu/exu_ctrl.sv
exu/exu_top.sv
tests/exu_tb.sv

//--- Makefile
SIM        := verilator
TOP        := exu_tb
RTL_TOP    := exu_top
FILELIST   := exu.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
